// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = exec_core_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = *** TEST FAILED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo '$(FAIL_MSG)' >> $(LOG)
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "No failure reported in $(LOG)"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== filelist.f ====
+incdir+rtl
rtl/rv32i_types.sv
rtl/exec_types.sv
rtl/id_stage.sv
rtl/reg_file.sv
rtl/alu_unit.sv
rtl/cmp_unit.sv
rtl/ex_combine.sv
rtl/exec_core.sv
testbench/exec_core_tb.sv

// ==== rtl/alu_unit.sv ====
`timescale 1ns/10ps

module alu_unit (
    input  exec_types::alu_op_t alu_op,
    input  logic                alu_a_pc,
    input  logic                alu_b_imm,
    input  exec_types::word_t   pc,
    input  exec_types::word_t   rs1_v,
    input  exec_types::word_t   rs2_v,
    input  exec_types::word_t   imm,
    output exec_types::word_t   alu_result
);
    import exec_types::*;

    word_t a, b;
    logic [4:0] shamt;

    assign a     = alu_a_pc ? pc : rs1_v;   // PC for AUIPC and JAL.
    assign b     = alu_b_imm ? imm : rs2_v;
    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            alu_add: alu_result = a + b;
            alu_sub: alu_result = a - b;
            alu_sll: alu_result = a << shamt;
            alu_srl: alu_result = a >> shamt;
            alu_sra: alu_result = word_t'($signed(a) >>> shamt);
            alu_xor: alu_result = a ^ b;
            alu_or:  alu_result = a | b;
            alu_and: alu_result = a & b;
            default: alu_result = a + b;
        endcase
    end

endmodule : alu_unit

// ==== rtl/cmp_unit.sv ====
`timescale 1ns/10ps

module cmp_unit (
    input  logic [2:0]        funct3,
    input  logic              is_slt,
    input  logic              cmp_b_imm,
    input  exec_types::word_t rs1_v,
    input  exec_types::word_t rs2_v,
    input  exec_types::word_t imm,
    output logic              cmp_true
);
    import rv32i_types::*;
    import exec_types::*;

    word_t b;
    logic eq, lt_s, lt_u;

    assign b    = cmp_b_imm ? imm : rs2_v; // SLTI and SLTIU use the immediate.
    assign eq   = (rs1_v == b);
    assign lt_s = ($signed(rs1_v) < $signed(b));
    assign lt_u = (rs1_v < b);

    always_comb begin
        if (is_slt) begin
            cmp_true = (funct3 == sltu) ? lt_u : lt_s;
        end else begin
            case (branch_f3_t'(funct3))
                beq:     cmp_true = eq;
                bne:     cmp_true = !eq;
                blt:     cmp_true = lt_s;
                bge:     cmp_true = !lt_s;
                bltu:    cmp_true = lt_u;
                bgeu:    cmp_true = !lt_u;
                default: cmp_true = 1'b0;   // Reserved codes never branch.
            endcase
        end
    end

endmodule : cmp_unit

// ==== rtl/ex_combine.sv ====
`timescale 1ns/10ps
`include "rv32i_defs.svh"

module ex_combine (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,
    input  logic                 dec_valid,
    input  exec_types::word_t    pc,
    input  exec_types::reg_idx_t rd_s,
    input  exec_types::word_t    imm,
    input  logic                 rd_wen,
    input  logic                 is_branch,
    input  logic                 is_jump,
    input  logic                 is_jalr,
    input  logic                 is_lui,
    input  logic                 is_slt,
    input  exec_types::word_t    alu_result,
    input  logic                 cmp_true,
    input  logic                 out_ready,
    output logic                 wr_en,
    output exec_types::reg_idx_t wr_idx,
    output exec_types::word_t    wr_data,
    output logic                 out_valid,
    output exec_types::word_t    out_pc,
    output exec_types::word_t    out_pc_next,
    output exec_types::reg_idx_t out_rd,
    output exec_types::word_t    out_rd_value,
    output logic                 out_wen
);
    import exec_types::*;

    word_t pc_plus4, rd_value, pc_next;
    logic  load, writes;

    assign load     = dec_valid && !stall;
    assign writes   = rd_wen && (rd_s != '0); // x0 destinations retire silently.
    assign pc_plus4 = pc + word_t'(4);

    always_comb begin
        if (is_lui)       rd_value = imm;
        else if (is_jump) rd_value = pc_plus4;  // Link address.
        else if (is_slt)  rd_value = {{(`XLEN-1){1'b0}}, cmp_true};
        else              rd_value = alu_result;
    end

    always_comb begin
        if (is_branch && cmp_true) pc_next = pc + imm;
        else if (is_jalr)          pc_next = {alu_result[`XLEN-1:1], 1'b0};
        else if (is_jump)          pc_next = alu_result;
        else                       pc_next = pc_plus4;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_wen   <= 1'b0;
            wr_en     <= 1'b0;
            out_pc    <= `RESET_PC;
        end else begin
            wr_en <= load && writes;   // One pulse per retired write.
            if (!stall) begin
                out_valid <= dec_valid;
            end
            if (load) begin
                out_wen <= writes;
                out_pc  <= pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_pc_next  <= pc_next;
            out_rd       <= rd_s;
            out_rd_value <= writes ? rd_value : '0;
        end
    end

    // The array is updated one edge later, covered by the register file bypass.
    assign wr_idx  = out_rd;
    assign wr_data = out_rd_value;

    assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> out_valid
            && $stable({out_pc, out_pc_next, out_rd, out_rd_value, out_wen}))
        else $error("output changed while held by back-pressure");

endmodule : ex_combine

// ==== rtl/exec_core.sv ====
`timescale 1ns/10ps

module exec_core (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  rv32i_types::instr_t  in_instr,
    input  exec_types::word_t    in_pc,
    output logic                 out_valid,
    input  logic                 out_ready,
    output exec_types::word_t    out_pc,
    output exec_types::word_t    out_pc_next,
    output exec_types::reg_idx_t out_rd,
    output exec_types::word_t    out_rd_value,
    output logic                 out_wen
);
    import exec_types::*;

    logic     stall, dec_valid;
    word_t    pc, imm, rs1_v, rs2_v, alu_result, wr_data;
    reg_idx_t rs1_s, rs2_s, rd_s, wr_idx;
    logic [2:0] funct3;
    alu_op_t  alu_op;
    logic     alu_a_pc, alu_b_imm, cmp_b_imm, cmp_true, wr_en;
    logic     is_branch, is_jump, is_jalr, is_lui, is_slt, rd_wen;

    // The whole pipe freezes while a result waits on the output.
    assign stall = out_valid && !out_ready;

    id_stage u_id (
        .clk, .rst, .in_valid, .in_instr, .in_pc, .stall, .in_ready,
        .dec_valid, .pc, .rs1_s, .rs2_s, .rd_s, .imm, .funct3, .alu_op,
        .alu_a_pc, .alu_b_imm, .cmp_b_imm, .is_branch, .is_jump, .is_jalr,
        .is_lui, .is_slt, .rd_wen
    );

    reg_file u_rf (
        .clk, .rst, .rs1_s, .rs2_s, .wr_en, .wr_idx, .wr_data, .rs1_v, .rs2_v
    );

    alu_unit u_alu (
        .alu_op, .alu_a_pc, .alu_b_imm, .pc, .rs1_v, .rs2_v, .imm, .alu_result
    );

    cmp_unit u_cmp (
        .funct3, .is_slt, .cmp_b_imm, .rs1_v, .rs2_v, .imm, .cmp_true
    );

    ex_combine u_ex (
        .clk, .rst, .stall, .dec_valid, .pc, .rd_s, .imm, .rd_wen,
        .is_branch, .is_jump, .is_jalr, .is_lui, .is_slt, .alu_result,
        .cmp_true, .out_ready, .wr_en, .wr_idx, .wr_data, .out_valid,
        .out_pc, .out_pc_next, .out_rd, .out_rd_value, .out_wen
    );

endmodule : exec_core

// ==== rtl/exec_types.sv ====
`include "rv32i_defs.svh"

package exec_types;

    // One data or address value.
    typedef logic [`XLEN-1:0] word_t;

    // Index into the register file.
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

    // ALU operations. Most codes follow funct3 directly.
    // SUB and SRA take the two slots that SLT and SLTU leave free,
    // since set-less-than is done by the comparator.
    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sub = 3'b010,
        alu_sra = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_op_t;

endpackage : exec_types

// ==== rtl/id_stage.sv ====
`timescale 1ns/10ps

module id_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  rv32i_types::instr_t    in_instr,
    input  exec_types::word_t      in_pc,
    input  logic                   stall,
    output logic                   in_ready,
    output logic                   dec_valid,
    output exec_types::word_t      pc,
    output exec_types::reg_idx_t   rs1_s,
    output exec_types::reg_idx_t   rs2_s,
    output exec_types::reg_idx_t   rd_s,
    output exec_types::word_t      imm,
    output logic [2:0]             funct3,
    output exec_types::alu_op_t    alu_op,
    output logic                   alu_a_pc,
    output logic                   alu_b_imm,
    output logic                   cmp_b_imm,
    output logic                   is_branch,
    output logic                   is_jump,
    output logic                   is_jalr,
    output logic                   is_lui,
    output logic                   is_slt,
    output logic                   rd_wen
);
    import rv32i_types::*;
    import exec_types::*;

    rv32i_opcode_t opcode;
    logic [2:0]    f3;
    logic          f7_b5;
    word_t         i_imm, s_imm, b_imm, u_imm, j_imm;
    word_t         imm_d;
    alu_op_t       alu_op_d;
    logic          a_pc_d, b_imm_d, cmp_imm_d;
    logic          branch_d, jump_d, jalr_d, lui_d, slt_d, wen_d;
    logic          accept;

    // OP and OP-IMM share the funct3 mapping. Only OP has SUB.
    function automatic alu_op_t arith_op(input logic [2:0] code, input logic alt,
                                         input logic reg_form);
        alu_op_t op;
        op = alu_op_t'(code);
        case (arith_f3_t'(code))
            add:       op = (alt && reg_form) ? alu_sub : alu_add;
            sr:        op = alt ? alu_sra : alu_srl;
            slt, sltu: op = alu_add; // Result comes from the comparator.
            default:   op = alu_op_t'(code);
        endcase
        return op;
    endfunction

    assign opcode = rv32i_opcode_t'(in_instr[6:0]);
    assign f3     = in_instr[14:12];
    assign f7_b5  = in_instr[30];

    assign i_imm = {{21{in_instr[31]}}, in_instr[30:20]};
    assign s_imm = {{21{in_instr[31]}}, in_instr[30:25], in_instr[11:7]};
    assign b_imm = {{20{in_instr[31]}}, in_instr[7], in_instr[30:25], in_instr[11:8], 1'b0};
    assign u_imm = {in_instr[31:12], 12'h000};
    assign j_imm = {{12{in_instr[31]}}, in_instr[19:12], in_instr[20], in_instr[30:21], 1'b0};

    always_comb begin
        imm_d     = '0;
        alu_op_d  = alu_add;
        a_pc_d    = 1'b0;
        b_imm_d   = 1'b0;
        cmp_imm_d = 1'b0;
        branch_d  = 1'b0;
        jump_d    = 1'b0;
        jalr_d    = 1'b0;
        lui_d     = 1'b0;
        slt_d     = 1'b0;
        wen_d     = 1'b0;
        case (opcode)
            op_b_reg: begin
                alu_op_d = arith_op(f3, f7_b5, 1'b1);
                slt_d    = (f3 == slt) || (f3 == sltu);
                wen_d    = 1'b1;
            end
            op_b_imm: begin
                imm_d     = i_imm;
                alu_op_d  = arith_op(f3, f7_b5, 1'b0);
                slt_d     = (f3 == slt) || (f3 == sltu);
                b_imm_d   = 1'b1;
                cmp_imm_d = 1'b1;
                wen_d     = 1'b1;
            end
            op_b_lui: begin
                imm_d = u_imm;
                lui_d = 1'b1;
                wen_d = 1'b1;
            end
            op_b_auipc: begin
                imm_d   = u_imm;
                a_pc_d  = 1'b1;
                b_imm_d = 1'b1;
                wen_d   = 1'b1;
            end
            op_b_jal: begin
                imm_d   = j_imm; // Target is PC plus offset in the ALU.
                a_pc_d  = 1'b1;
                b_imm_d = 1'b1;
                jump_d  = 1'b1;
                wen_d   = 1'b1;
            end
            op_b_jalr: begin
                imm_d   = i_imm;
                b_imm_d = 1'b1;
                jump_d  = 1'b1;
                jalr_d  = 1'b1;
                wen_d   = 1'b1;
            end
            op_b_br: begin
                imm_d    = b_imm;
                branch_d = 1'b1;
            end
            op_b_load:  imm_d = i_imm;
            op_b_store: imm_d = s_imm;
            default: ;  // Anything else retires as a no-op.
        endcase
    end

    assign in_ready = !stall;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (!stall) begin
            dec_valid <= in_valid; // Drains when nothing new arrives.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pc        <= in_pc;
            rs1_s     <= in_instr[19:15];
            rs2_s     <= in_instr[24:20];
            rd_s      <= in_instr[11:7];
            imm       <= imm_d;
            funct3    <= f3;
            alu_op    <= alu_op_d;
            alu_a_pc  <= a_pc_d;
            alu_b_imm <= b_imm_d;
            cmp_b_imm <= cmp_imm_d;
            is_branch <= branch_d;
            is_jump   <= jump_d;
            is_jalr   <= jalr_d;
            is_lui    <= lui_d;
            is_slt    <= slt_d;
            rd_wen    <= wen_d;
        end
    end

    // A stalled decode entry must survive until the output register takes it.
    assert property (@(posedge clk) disable iff (rst)
        (stall && dec_valid) |=> dec_valid && $stable({pc, rd_s, rs1_s, rs2_s, imm, rd_wen}))
        else $error("decode register changed during stall");

endmodule : id_stage

// ==== rtl/reg_file.sv ====
`timescale 1ns/10ps
`include "rv32i_defs.svh"

module reg_file (
    input  logic                 clk,
    input  logic                 rst,
    input  exec_types::reg_idx_t rs1_s,
    input  exec_types::reg_idx_t rs2_s,
    input  logic                 wr_en,
    input  exec_types::reg_idx_t wr_idx,
    input  exec_types::word_t    wr_data,
    output exec_types::word_t    rs1_v,
    output exec_types::word_t    rs2_v
);
    import exec_types::*;

    word_t regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Write-through so a reader sees data written on the coming edge.
    always_comb begin
        if (rs1_s == '0)                      rs1_v = '0;
        else if (wr_en && (wr_idx == rs1_s))  rs1_v = wr_data;
        else                                  rs1_v = regs[rs1_s];
        if (rs2_s == '0)                      rs2_v = '0;
        else if (wr_en && (wr_idx == rs2_s))  rs2_v = wr_data;
        else                                  rs2_v = regs[rs2_s];
    end

    assert property (@(posedge clk) disable iff (rst)
        !(wr_en && (wr_idx == '0) && (wr_data != '0)))
        else $error("nonzero write to x0");

endmodule : reg_file

// ==== rtl/rv32i_defs.svh ====
`ifndef RV32I_DEFS_SVH
`define RV32I_DEFS_SVH

// Data and address width of the integer core.
`define XLEN 32

// Architectural register count, x0 included.
`define NUM_REGS 32

// PC shown on the output port while the output register is still empty.
`define RESET_PC 32'h0000_0000

`endif

// ==== rtl/rv32i_types.sv ====
package rv32i_types;

    // Raw 32-bit instruction word as it arrives on the input stream.
    typedef logic [31:0] instr_t;

    // Major opcodes, bits 6:0 of the instruction word.
    typedef enum logic [6:0] {
        op_b_lui   = 7'b0110111,
        op_b_auipc = 7'b0010111,
        op_b_jal   = 7'b1101111,
        op_b_jalr  = 7'b1100111,
        op_b_br    = 7'b1100011,
        op_b_load  = 7'b0000011,
        op_b_store = 7'b0100011,
        op_b_imm   = 7'b0010011,
        op_b_reg   = 7'b0110011
    } rv32i_opcode_t;

    // Funct3 of OP and OP-IMM.
    typedef enum logic [2:0] {
        add  = 3'b000, // Also SUB when funct7 bit 5 is set on OP.
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        sr   = 3'b101, // SRL or SRA, picked by funct7 bit 5.
        aor  = 3'b110,
        aand = 3'b111
    } arith_f3_t;

    // Funct3 of the conditional branches.
    // Codes 010 and 011 are not used by any branch.
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_f3_t;

endpackage : rv32i_types

// ==== testbench/exec_core_tb.sv ====
`timescale 1ns/10ps

module exec_core_tb;

    localparam int clk_period   = 40;
    localparam int total_instrs = 900;  // Sum of the instruction counts of all tests.

    localparam logic [6:0] opc_lui   = 7'b0110111;
    localparam logic [6:0] opc_auipc = 7'b0010111;
    localparam logic [6:0] opc_jal   = 7'b1101111;
    localparam logic [6:0] opc_jalr  = 7'b1100111;
    localparam logic [6:0] opc_br    = 7'b1100011;
    localparam logic [6:0] opc_load  = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;
    localparam logic [6:0] opc_imm   = 7'b0010011;
    localparam logic [6:0] opc_reg   = 7'b0110011;
    localparam logic [6:0] opc_misc  = 7'b0001111;

    logic        clk = 1'b0;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] in_instr;
    logic [31:0] in_pc;
    logic        out_valid;
    logic        out_ready;
    logic [31:0] out_pc;
    logic [31:0] out_pc_next;
    logic [4:0]  out_rd;
    logic [31:0] out_rd_value;
    logic        out_wen;

    // Reference model state and the results still owed by the DUT.
    logic [31:0] model_regs [32];
    logic [31:0] exp_pc_q [$];
    logic [31:0] exp_next_q [$];
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_val_q [$];
    logic        exp_wen_q [$];
    logic [4:0]  last_rd;
    int          error_count;
    int          check_count;
    int          test_count;

    exec_core dut (.*);

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [4:0] pick_reg();
        return 5'($urandom % 8);  // x0 to x7 keeps dependences frequent.
    endfunction

    function automatic bit coin();
        return ($urandom % 2) == 1;
    endfunction

    // Legal arithmetic codes without SLT and SLTU, which are also the six branch codes.
    function automatic logic [2:0] pick_f3_skip_slt();
        logic [2:0] f3;
        f3 = 3'($urandom);
        while (f3 == 3'd2 || f3 == 3'd3) begin
            f3 = 3'($urandom);
        end
        return f3;
    endfunction

    function automatic logic [31:0] make_arith(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        logic [2:0]  f3;
        logic [11:0] imm12;
        logic [6:0]  f7;
        f3    = pick_f3_skip_slt();
        imm12 = 12'($urandom);
        f7    = ((f3 == 3'd0 || f3 == 3'd5) && coin()) ? 7'h20 : 7'h00;
        if (coin()) begin
            return {f7, rs2, rs1, f3, rd, opc_reg};
        end
        if (f3 == 3'd1 || f3 == 3'd5) begin
            imm12 = {f7, imm12[4:0]};  // Shift amount, with the SRAI flag above it.
        end
        return {imm12, rs1, f3, rd, opc_imm};
    endfunction

    function automatic logic [31:0] make_compare(input logic [4:0] rd, input logic [4:0] rs1,
                                                 input logic [4:0] rs2);
        logic [2:0]  f3;
        logic [12:0] off;
        logic [4:0]  rb;
        if (coin()) begin
            f3  = pick_f3_skip_slt();
            off = 13'($urandom) & 13'h1ffc;
            rb  = coin() ? rs1 : rs2;  // Equal operands make BEQ and BGE take often.
            return {off[12], off[10:5], rb, rs1, f3, off[4:1], off[11], opc_br};
        end
        f3 = coin() ? 3'd2 : 3'd3;
        if (coin()) begin
            return {7'h00, rs2, rs1, f3, rd, opc_reg};
        end
        return {12'($urandom), rs1, f3, rd, opc_imm};
    endfunction

    function automatic logic [31:0] make_upper_jump(input logic [4:0] rd, input logic [4:0] rs1);
        logic [20:0] off;
        logic [4:0]  rd_x;
        rd_x = (($urandom % 4) == 0) ? 5'd0 : rd;
        off  = 21'($urandom) & 21'h1ffffc;
        case ($urandom % 4)
            0: return {20'($urandom), rd_x, opc_lui};
            1: return {20'($urandom), rd_x, opc_auipc};
            2: return {off[20], off[10:1], off[11], off[19:12], rd_x, opc_jal};
            default: return {12'($urandom), rs1, 3'b000, rd_x, opc_jalr};
        endcase
    endfunction

    function automatic logic [31:0] make_memory(input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [4:0] rs2);
        case ($urandom % 3)
            0: return {12'($urandom), rs1, 3'b010, rd, opc_load};
            1: return {7'($urandom), rs2, rs1, 3'b010, 5'($urandom), opc_store};
            default: return {25'($urandom), opc_misc};
        endcase
    endfunction

    // Kind 0 arithmetic, 1 compare, 2 upper and jump, 3 mix of those, 4 memory mixed with ALU.
    function automatic logic [31:0] make_instr(input int kind);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] word;
        int          sel;
        rd  = pick_reg();
        rs1 = (($urandom % 3) == 0) ? last_rd : pick_reg();
        rs2 = pick_reg();
        sel = kind;
        if (kind == 3) begin
            sel = int'($urandom % 3);
        end else if (kind == 4) begin
            sel = coin() ? 0 : 4;
        end
        case (sel)
            0: word = make_arith(rd, rs1, rs2);
            1: word = make_compare(rd, rs1, rs2);
            2: word = make_upper_jump(rd, rs1);
            default: word = make_memory(rd, rs1, rs2);
        endcase
        last_rd = word[11:7];
        return word;
    endfunction

    function automatic logic [31:0] arith_result(input logic [2:0] f3, input logic alt,
                                                 input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return sa >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Executes one instruction in program order and queues what the DUT must report.
    task automatic model_accept(input logic [31:0] ins, input logic [31:0] pc);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] val;
        logic [31:0] nxt;
        logic        wen;
        a     = model_regs[ins[19:15]];
        b     = model_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        val   = 32'd0;
        nxt   = pc + 32'd4;
        wen   = 1'b1;
        case (ins[6:0])
            opc_reg:   val = arith_result(ins[14:12], ins[30], a, b);
            opc_imm:   val = arith_result(ins[14:12], (ins[14:12] == 3'd5) && ins[30], a, imm_i);
            opc_lui:   val = {ins[31:12], 12'd0};
            opc_auipc: val = pc + {ins[31:12], 12'd0};
            opc_jal: begin
                val = pc + 32'd4;
                nxt = pc + imm_j;
            end
            opc_jalr: begin
                val = pc + 32'd4;
                nxt = (a + imm_i) & 32'hffff_fffe;
            end
            opc_br: begin
                wen = 1'b0;
                if (branch_taken(ins[14:12], a, b)) begin
                    nxt = pc + imm_b;
                end
            end
            default: wen = 1'b0;  // Loads, stores and unknown opcodes.
        endcase
        if (ins[11:7] == 5'd0) begin
            wen = 1'b0;
        end
        if (wen) begin
            model_regs[ins[11:7]] = val;
        end
        exp_pc_q.push_back(pc);
        exp_next_q.push_back(nxt);
        exp_rd_q.push_back(ins[11:7]);
        exp_val_q.push_back(val);
        exp_wen_q.push_back(wen);
    endtask

    task automatic report_mismatch(input string field, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Fail at %0t ns: %s is %h, expected %h", $time, field, got, exp);
        error_count++;
    endtask

    task automatic check_output();
        logic [31:0] e_pc;
        logic [31:0] e_next;
        logic [4:0]  e_rd;
        logic [31:0] e_val;
        logic        e_wen;
        if (exp_pc_q.size() == 0) begin
            $display("Extra result at %0t ns with pc %h and nothing outstanding", $time, out_pc);
            error_count++;
        end else begin
            e_pc   = exp_pc_q.pop_front();
            e_next = exp_next_q.pop_front();
            e_rd   = exp_rd_q.pop_front();
            e_val  = exp_val_q.pop_front();
            e_wen  = exp_wen_q.pop_front();
            check_count++;
            if (out_pc !== e_pc) report_mismatch("out_pc", out_pc, e_pc);
            if (out_pc_next !== e_next) report_mismatch("out_pc_next", out_pc_next, e_next);
            if (out_wen !== e_wen) report_mismatch("out_wen", 32'(out_wen), 32'(e_wen));
            if (out_rd !== e_rd) report_mismatch("out_rd", 32'(out_rd), 32'(e_rd));
            if (e_wen && (out_rd_value !== e_val)) begin
                report_mismatch("out_rd_value", out_rd_value, e_val);
            end
        end
    endtask

    task automatic check_reset_state();
        int errors_before;
        errors_before = error_count;
        repeat (3) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                $display("Fail at %0t ns: out_valid is high after reset", $time);
                error_count++;
            end
            if (in_ready !== 1'b1) begin
                $display("Fail at %0t ns: in_ready is low after reset", $time);
                error_count++;
            end
        end
        @(posedge clk);
        #2;
        test_count++;
        $display("Test %0d reset state: %0d errors", test_count, error_count - errors_before);
    endtask

    // Sends count instructions, then waits until every result has come out.
    task automatic run_test(input string name, input int kind, input int count,
                            input bit rand_ready, input bit rand_gaps);
        int accepted;
        int errors_before;
        bit holding;
        accepted      = 0;
        errors_before = error_count;
        holding       = 1'b0;
        while (accepted < count || exp_pc_q.size() != 0) begin
            if (!holding && accepted < count && (!rand_gaps || ($urandom % 4) != 0)) begin
                in_instr = make_instr(kind);
                in_pc    = $urandom & 32'hffff_fffc;
                holding  = 1'b1;
            end
            in_valid  = holding;
            out_ready = rand_ready ? (($urandom % 3) != 0) : 1'b1;
            @(negedge clk);  // Both handshakes are settled for the coming edge.
            if (out_valid && out_ready) check_output();
            if (in_valid && in_ready) begin
                model_accept(in_instr, in_pc);
                accepted++;
                holding = 1'b0;
            end
            @(posedge clk);
            #2;
        end
        in_valid = 1'b0;
        test_count++;
        $display("Test %0d %s: %0d instructions, %0d errors", test_count, name, count,
                 error_count - errors_before);
    endtask

    initial begin
        #(total_instrs * 20 * clk_period);
        $display("Timeout: the run did not finish within %0d ns", total_instrs * 20 * clk_period);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(60));
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_instr    = 32'd0;
        in_pc       = 32'd0;
        out_ready   = 1'b0;
        last_rd     = 5'd0;
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'd0;
        end
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        // With out_ready low, in_ready stays high only while the output register is empty.
        check_reset_state();
        run_test("arithmetic", 0, 200, 1'b0, 1'b0);
        run_test("branches and set-less-than", 1, 200, 1'b0, 1'b0);
        run_test("upper immediates and jumps", 2, 100, 1'b0, 1'b0);
        run_test("mixed with back-pressure and gaps", 3, 300, 1'b1, 1'b1);
        run_test("loads, stores and unknown opcodes", 4, 100, 1'b0, 1'b1);

        $display("Done: %0d tests, %0d results checked, %0d errors", test_count, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : exec_core_tb
